// File: Bender.yml
package:
  name: io_subsystem

sources:
  - io_pkg.sv
  - io_regfile.sv
  - gpio_unit.sv
  - timer_unit.sv
  - interrupt_controller.sv
  - io_subsystem.sv
  - target: simulation
    files:
      - tb_io_subsystem.sv

// File: gpio_unit.sv
`timescale 1ns/1ps
/* gpio unit
   registered pin drivers for ports a and b from the ddr and port registers */
module gpio_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         ddra,
    input  logic [7:0]         porta,
    input  logic [7:0]         ddrb,
    input  logic [7:0]         portb,
    output io_pkg::gpio_port_t pa,
    output io_pkg::gpio_port_t pb
);
    import io_pkg::*;

    // input bits show 0 so a released pin carries no stale value
    function automatic gpio_port_t pin_drive(input logic [7:0] ddr, input logic [7:0] port);
        gpio_port_t drv;
        drv.out = port & ddr;
        drv.oe  = ddr;
        return drv;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            pa <= '0;   // all pins undriven
            pb <= '0;
        end else begin
            pa <= pin_drive(ddra, porta);
            pb <= pin_drive(ddrb, portb);
        end
    end

endmodule

// File: interrupt_controller.sv
`timescale 1ns/1ps
/* interrupt controller
   masks timer flags, picks a vector by fixed priority and clears the served flag on ack */
module interrupt_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          tifr,
    input  logic [7:0]          timsk,
    input  logic [7:0]          sreg,
    input  logic                irq_ack,
    output logic                irq,
    output io_pkg::irq_vector_e vector,
    output logic [7:0]          flag_clr
);
    import io_pkg::*;

    logic [7:0]  pending;
    irq_vector_e sel;

    assign pending = tifr & timsk & {8{sreg[bit_sreg_i]}};

    // compa over compb over overflow
    always_comb begin
        if (pending[bit_ocf0a]) begin
            sel = vec_tim0_compa;
        end else if (pending[bit_ocf0b]) begin
            sel = vec_tim0_compb;
        end else if (pending[bit_tov0]) begin
            sel = vec_tim0_ovf;
        end else begin
            sel = vec_none;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq    <= 1'b0;
            vector <= vec_none;
        end else begin
            irq    <= (sel != vec_none);
            vector <= sel;
        end
    end

    // only the flag behind the served vector
    always_comb begin
        flag_clr = '0;
        if (irq_ack) begin
            case (vector)
                vec_tim0_compa: flag_clr[bit_ocf0a] = 1'b1;
                vec_tim0_compb: flag_clr[bit_ocf0b] = 1'b1;
                vec_tim0_ovf:   flag_clr[bit_tov0]  = 1'b1;
                default:        flag_clr = '0;
            endcase
        end
    end

    irq_has_vector: assert property (
        @(posedge clk) disable iff (reset) irq |-> (vector != vec_none)
    );

endmodule

// File: io_pkg.sv
/* io subsystem package
   register map, bit positions, vector and clock-select encodings, bus and port structs */
package io_pkg;

    localparam int data_width   = 8;
    localparam int addr_width   = 6;    // 64 io registers
    localparam int i_addr_width = 10;   // 1024 instruction words
    localparam int num_regs     = 64;

    // io register map
    localparam logic [addr_width-1:0] addr_pina   = 6'h00;  // read-only
    localparam logic [addr_width-1:0] addr_ddra   = 6'h01;
    localparam logic [addr_width-1:0] addr_porta  = 6'h02;
    localparam logic [addr_width-1:0] addr_pinb   = 6'h03;  // read-only
    localparam logic [addr_width-1:0] addr_ddrb   = 6'h04;
    localparam logic [addr_width-1:0] addr_portb  = 6'h05;
    localparam logic [addr_width-1:0] addr_tccr0a = 6'h06;
    localparam logic [addr_width-1:0] addr_tccr0b = 6'h07;
    localparam logic [addr_width-1:0] addr_tcnt0  = 6'h08;
    localparam logic [addr_width-1:0] addr_ocr0a  = 6'h09;
    localparam logic [addr_width-1:0] addr_ocr0b  = 6'h0A;
    localparam logic [addr_width-1:0] addr_tifr   = 6'h0B;
    localparam logic [addr_width-1:0] addr_timsk  = 6'h0C;
    localparam logic [addr_width-1:0] addr_sreg   = 6'h3F;

    // flag positions, same in tifr and timsk
    localparam int bit_tov0  = 0;
    localparam int bit_ocf0a = 1;
    localparam int bit_ocf0b = 2;

    localparam int bit_sreg_i = 7;   // global interrupt enable

    // tccr0a fields
    localparam int bit_wgm_ctc = 1;  // clear on compare a
    localparam int bit_com0a   = 6;  // toggle oc0a on match
    localparam int bit_com0b   = 4;  // toggle oc0b on match

    // low bits of tccr0b
    typedef enum logic [1:0] {
        cs_stop  = 2'd0,
        cs_div1  = 2'd1,
        cs_div8  = 2'd2,
        cs_div64 = 2'd3
    } clk_sel_e;

    typedef enum logic [i_addr_width-1:0] {
        vec_none       = 10'h000,
        vec_tim0_compa = 10'h00E,
        vec_tim0_compb = 10'h00F,
        vec_tim0_ovf   = 10'h010
    } irq_vector_e;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [addr_width-1:0] adr;
        logic [data_width-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [data_width-1:0] dat;
    } wb_rsp_t;

    // pin driver, oe high means driven
    typedef struct packed {
        logic [data_width-1:0] out;
        logic [data_width-1:0] oe;
    } gpio_port_t;

    typedef struct packed {
        logic [data_width-1:0] tccr0a;
        logic [data_width-1:0] tccr0b;
        logic [data_width-1:0] ocr0a;
        logic [data_width-1:0] ocr0b;
    } timer_cfg_t;

endpackage

// File: io_regfile.sv
`timescale 1ns/1ps
/* io register file
   wishbone classic slave over 64 byte registers, pin sampling and tcnt0/tifr arbitration */
module io_regfile (
    input  logic               clk,
    input  logic               reset,
    input  io_pkg::wb_req_t    wb_req,
    output io_pkg::wb_rsp_t    wb_rsp,
    input  logic [7:0]         pa_in,
    input  logic [7:0]         pb_in,
    input  logic [7:0]         tcnt_next,
    input  logic [7:0]         flag_set,
    input  logic [7:0]         flag_clr,
    output logic [7:0]         ddra,
    output logic [7:0]         porta,
    output logic [7:0]         ddrb,
    output logic [7:0]         portb,
    output io_pkg::timer_cfg_t timer_cfg,
    output logic [7:0]         tcnt0,
    output logic [7:0]         tifr,
    output logic [7:0]         timsk,
    output logic [7:0]         sreg
);
    import io_pkg::*;

    logic [data_width-1:0] regs [num_regs];
    logic                  req;
    logic                  ack_q;
    logic [data_width-1:0] rdat_q;
    logic                  host_wr;
    logic                  wr_tcnt0;
    logic                  wr_tifr;
    logic [data_width-1:0] tifr_hw;

    assign req      = wb_req.cyc && wb_req.stb;
    assign host_wr  = req && !ack_q && wb_req.we;   // commits on the ack edge
    assign wr_tcnt0 = host_wr && (wb_req.adr == addr_tcnt0);
    assign wr_tifr  = host_wr && (wb_req.adr == addr_tifr);

    // set by timer events, cleared by interrupt acknowledge
    assign tifr_hw = (regs[addr_tifr] | flag_set) & ~flag_clr;

    // one wait state, ack every second cycle at most
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdat_q <= '0;
        end else if (req && !ack_q) begin
            rdat_q <= regs[wb_req.adr];   // valid while ack high
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_wr) begin
                regs[wb_req.adr] <= wb_req.dat;
            end
            // pins reload every cycle and override any host write
            regs[addr_pina] <= pa_in;
            regs[addr_pinb] <= pb_in;

            // host beats the timer on tcnt0 and tifr
            if (wr_tcnt0) begin
                regs[addr_tcnt0] <= wb_req.dat;
            end else begin
                regs[addr_tcnt0] <= tcnt_next;
            end
            if (wr_tifr) begin
                regs[addr_tifr] <= wb_req.dat;
            end else begin
                regs[addr_tifr] <= tifr_hw;
            end
        end
    end

    assign ddra  = regs[addr_ddra];
    assign porta = regs[addr_porta];
    assign ddrb  = regs[addr_ddrb];
    assign portb = regs[addr_portb];
    assign tcnt0 = regs[addr_tcnt0];
    assign tifr  = regs[addr_tifr];
    assign timsk = regs[addr_timsk];
    assign sreg  = regs[addr_sreg];

    assign timer_cfg.tccr0a = regs[addr_tccr0a];
    assign timer_cfg.tccr0b = regs[addr_tccr0b];
    assign timer_cfg.ocr0a  = regs[addr_ocr0a];
    assign timer_cfg.ocr0b  = regs[addr_ocr0b];

    // no back-to-back acks, even with stb held
    ack_not_back_to_back: assert property (
        @(posedge clk) disable iff (reset) ack_q |=> !ack_q
    );

    // every ack answers a request seen on the previous clock
    ack_follows_req: assert property (
        @(posedge clk) disable iff (reset) ack_q |-> $past(req)
    );

endmodule

// File: io_subsystem.sv
`timescale 1ns/1ps
/* io subsystem top
   register file with gpio, timer0 and interrupt controller behind a wishbone port */
module io_subsystem (
    input  logic                clk,
    input  logic                reset,
    input  io_pkg::wb_req_t     wb_req,
    output io_pkg::wb_rsp_t     wb_rsp,
    input  logic [7:0]          pa_in,
    input  logic [7:0]          pb_in,
    output io_pkg::gpio_port_t  pa,
    output io_pkg::gpio_port_t  pb,
    output logic                oc0a,
    output logic                oc0b,
    input  logic                irq_ack,
    output logic                irq,
    output io_pkg::irq_vector_e vector
);
    import io_pkg::*;

    logic [7:0] ddra;
    logic [7:0] porta;
    logic [7:0] ddrb;
    logic [7:0] portb;
    timer_cfg_t timer_cfg;
    logic [7:0] tcnt0;
    logic [7:0] tifr;
    logic [7:0] timsk;
    logic [7:0] sreg;
    logic [7:0] tcnt_next;
    logic [7:0] flag_set;
    logic [7:0] flag_clr;

    io_regfile regfile0 (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .pa_in     (pa_in),
        .pb_in     (pb_in),
        .tcnt_next (tcnt_next),
        .flag_set  (flag_set),
        .flag_clr  (flag_clr),
        .ddra      (ddra),
        .porta     (porta),
        .ddrb      (ddrb),
        .portb     (portb),
        .timer_cfg (timer_cfg),
        .tcnt0     (tcnt0),
        .tifr      (tifr),
        .timsk     (timsk),
        .sreg      (sreg)
    );

    gpio_unit gpio0 (
        .clk   (clk),
        .reset (reset),
        .ddra  (ddra),
        .porta (porta),
        .ddrb  (ddrb),
        .portb (portb),
        .pa    (pa),
        .pb    (pb)
    );

    timer_unit timer0 (
        .clk       (clk),
        .reset     (reset),
        .timer_cfg (timer_cfg),
        .tcnt0     (tcnt0),
        .tcnt_next (tcnt_next),
        .flag_set  (flag_set),
        .oc0a      (oc0a),
        .oc0b      (oc0b)
    );

    interrupt_controller pic0 (
        .clk      (clk),
        .reset    (reset),
        .tifr     (tifr),
        .timsk    (timsk),
        .sreg     (sreg),
        .irq_ack  (irq_ack),
        .irq      (irq),
        .vector   (vector),
        .flag_clr (flag_clr)
    );

endmodule

// File: tb_io_subsystem.sv
`timescale 1ns/1ps
/* io subsystem testbench
   table-driven wishbone accesses with checks on pins, timer0 and interrupts */
module tb_io_subsystem;
    import io_pkg::*;

    typedef enum logic [1:0] {op_write, op_read, op_wait_irq, op_ack_irq} op_e;

    // on a read, dat is the compare mask
    typedef struct packed {
        op_e        op;
        logic [5:0] adr;
        logic [7:0] dat;
        logic [9:0] exp;
        logic [3:0] test;
    } step_t;

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [7:0]  pa_in;
    logic [7:0]  pb_in;
    gpio_port_t  pa;
    gpio_port_t  pb;
    logic        oc0a;
    logic        oc0b;
    logic        irq_ack;
    logic        irq;
    irq_vector_e vector;

    step_t       steps[$];
    integer      seed;
    int          test_errs;
    int          total_errs;
    int          pass_count;
    int          fail_count;
    logic        timed_out;

    io_subsystem dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, msg, got, exp);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic drive_bus(input logic active, input logic we, input logic [5:0] adr,
                             input logic [7:0] dat);
        wb_req.cyc = active;
        wb_req.stb = active;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
    endtask

    task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int n;
        drive_bus(1'b1, we, adr, wdat);
        n = 0;
        rdat = '0;
        do begin
            tick();
            n++;
        end while (!wb_rsp.ack && n < 20);
        if (!wb_rsp.ack) begin
            $display("timeout: no ack within 20 cycles for address 0x%02h", adr);
            timed_out = 1'b1;
        end else begin
            rdat = wb_rsp.dat;
            tick();   // stb drops the cycle after ack
        end
        drive_bus(1'b0, 1'b0, '0, '0);
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [5:0] adr, output logic [7:0] dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level && n < 2000) begin
            tick();
            n++;
        end
        if (irq !== level) begin
            $display("timeout: irq did not reach %0b within 2000 cycles", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic ack_irq();
        irq_ack = 1'b1;
        tick();
        irq_ack = 1'b0;
    endtask

    task automatic new_pin_values();
        logic [31:0] rnd;
        rnd   = $random(seed);
        pa_in = rnd[7:0];
        rnd   = $random(seed);
        pb_in = rnd[15:8];
    endtask

    task automatic add_step(input op_e op, input logic [5:0] adr, input logic [7:0] dat,
                            input logic [9:0] exp, input logic [3:0] test);
        step_t s;
        s.op   = op;
        s.adr  = adr;
        s.dat  = dat;
        s.exp  = exp;
        s.test = test;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(op_read,  6'h20, 8'hFF, 10'h000, 1);
        add_step(op_read,  addr_tifr, 8'hFF, 10'h000, 1);
        add_step(op_write, 6'h20, 8'h5A, 10'h000, 1);
        add_step(op_read,  6'h20, 8'hFF, 10'h05A, 1);
        add_step(op_write, 6'h3E, 8'hC3, 10'h000, 1);
        add_step(op_read,  6'h3E, 8'hFF, 10'h0C3, 1);
        add_step(op_write, addr_ddra, 8'hF0, 10'h000, 1);
        add_step(op_write, addr_porta, 8'hA5, 10'h000, 1);
        add_step(op_write, addr_ddrb, 8'h0F, 10'h000, 1);
        add_step(op_write, addr_portb, 8'h3C, 10'h000, 1);
        add_step(op_write, addr_pina, 8'hFF, 10'h000, 2);     // must be ignored
        add_step(op_write, addr_tccr0b, 8'h00, 10'h000, 3);
        add_step(op_write, addr_tcnt0, 8'h42, 10'h000, 3);
        add_step(op_read,  addr_tcnt0, 8'hFF, 10'h042, 3);
        add_step(op_write, addr_tccr0a, 8'h00, 10'h000, 4);   // normal mode
        add_step(op_write, addr_tcnt0, 8'hF0, 10'h000, 4);
        add_step(op_write, addr_timsk, 8'h01, 10'h000, 4);
        add_step(op_write, addr_sreg, 8'h80, 10'h000, 4);
        add_step(op_write, addr_tccr0b, 8'h01, 10'h000, 4);
        add_step(op_wait_irq, 6'h00, 8'h00, vec_tim0_ovf, 4);
        add_step(op_read,  addr_tifr, 8'h01, 10'h001, 4);
        add_step(op_ack_irq, 6'h00, 8'h00, 10'h000, 4);
        add_step(op_read,  addr_tifr, 8'h01, 10'h000, 4);
        add_step(op_wait_irq, 6'h00, 8'h00, vec_none, 4);
        add_step(op_write, addr_tccr0b, 8'h00, 10'h000, 4);
        add_step(op_write, addr_sreg, 8'h00, 10'h000, 5);     // let flags pend quietly
        add_step(op_write, addr_tifr, 8'h00, 10'h000, 5);
        add_step(op_write, addr_tcnt0, 8'h00, 10'h000, 5);
        add_step(op_write, addr_ocr0a, 8'h10, 10'h000, 5);
        add_step(op_write, addr_ocr0b, 8'h08, 10'h000, 5);
        add_step(op_write, addr_tccr0a, 8'h52, 10'h000, 5);   // ctc, toggle oc0a and oc0b
        add_step(op_write, addr_timsk, 8'h03, 10'h000, 5);
        add_step(op_write, addr_tccr0b, 8'h01, 10'h000, 5);
        add_step(op_write, addr_tccr0b, 8'h00, 10'h000, 6);
        add_step(op_write, addr_tifr, 8'h00, 10'h000, 6);
        add_step(op_read,  addr_tifr, 8'hFF, 10'h000, 6);
        add_step(op_wait_irq, 6'h00, 8'h00, vec_none, 6);
    endtask

    task automatic run_step(input step_t s);
        logic [7:0] rd;
        case (s.op)
            op_write: wb_write(s.adr, s.dat);
            op_read: begin
                wb_read(s.adr, rd);
                check_value(rd & s.dat, s.exp[7:0] & s.dat, $sformatf("read 0x%02h", s.adr));
            end
            op_wait_irq: begin
                wait_irq(s.exp != 10'h000);
                if (!timed_out) begin
                    check_value(vector, s.exp, "irq vector");
                end
            end
            default: ack_irq();
        endcase
    endtask

    // checks that do not fit a table row
    task automatic run_directed(input int test);
        logic [7:0] rd;
        logic       lvl;
        int         n;
        case (test)
            1: begin
                tick();
                check_value(pa.oe, 8'hF0, "pa.oe");
                check_value(pa.out, 8'hA0, "pa.out");
                check_value(pb.oe, 8'h0F, "pb.oe");
                check_value(pb.out, 8'h0C, "pb.out");
            end
            2: begin
                wb_read(addr_pina, rd);
                check_value(rd, pa_in, "pina after write");
                new_pin_values();
                repeat (3) tick();
                wb_read(addr_pina, rd);
                check_value(rd, pa_in, "pina");
                wb_read(addr_pinb, rd);
                check_value(rd, pb_in, "pinb");
            end
            3: begin
                repeat (6) tick();
                wb_read(addr_tcnt0, rd);
                check_value(rd, 8'h42, "stopped tcnt0");
            end
            5: begin
                lvl = oc0a;
                n = 0;
                while (oc0a === lvl && n < 100) begin
                    tick();
                    n++;
                end
                check_value(oc0a !== lvl, 1'b1, "oc0a toggle on compare a");
                lvl = oc0b;
                n = 0;
                while (oc0b === lvl && n < 100) begin
                    tick();
                    n++;
                end
                check_value(oc0b !== lvl, 1'b1, "oc0b toggle on compare b");
                wb_read(addr_tifr, rd);
                check_value(rd[bit_ocf0a], 1'b1, "ocf0a set");
                for (int i = 0; i < 30; i++) begin
                    wb_read(addr_tcnt0, rd);
                    check_value(rd <= 8'h10, 1'b1, $sformatf("ctc count 0x%02h above top", rd));
                end
                wb_write(addr_tcnt0, 8'hF8);   // pass through overflow once
                rd = '0;
                n = 0;
                while (!rd[bit_tov0] && n < 20) begin
                    wb_read(addr_tifr, rd);
                    n++;
                end
                check_value(rd[bit_tov0], 1'b1, "tov0 pending");
                wb_write(addr_sreg, 8'h80);
                wait_irq(1'b1);
                check_value(vector, vec_tim0_compa, "vector with compa and ovf pending");
            end
            default: ;
        endcase
    endtask

    task automatic report_test(input int test);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d ok", test);
        end else begin
            fail_count++;
            $display("test %0d: %0d errors", test, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        seed       = 76883;
        reset      = 1'b1;
        irq_ack    = 1'b0;
        timed_out  = 1'b0;
        test_errs  = 0;
        total_errs = 0;
        pass_count = 0;
        fail_count = 0;
        drive_bus(1'b0, 1'b0, '0, '0);
        new_pin_values();
        build_table();
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        check_value(irq, 1'b0, "irq after reset");
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            if (timed_out) break;
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                run_directed(steps[i].test);
                if (timed_out) break;
                report_test(steps[i].test);
            end
        end
        $display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
        if (timed_out || fail_count != 0 || total_errs != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

// File: timer_unit.sv
`timescale 1ns/1ps
/* timer0
   prescaled 8-bit counter with normal and ctc modes, compare flags and toggle outputs */
module timer_unit (
    input  logic               clk,
    input  logic               reset,
    input  io_pkg::timer_cfg_t timer_cfg,
    input  logic [7:0]         tcnt0,
    output logic [7:0]         tcnt_next,
    output logic [7:0]         flag_set,
    output logic               oc0a,
    output logic               oc0b
);
    import io_pkg::*;

    clk_sel_e   cs;
    logic [5:0] psc;
    logic       tick;
    logic       ctc_mode;
    logic       match_a;
    logic       match_b;
    logic       ovf;

    assign cs       = clk_sel_e'(timer_cfg.tccr0b[1:0]);
    assign ctc_mode = timer_cfg.tccr0a[bit_wgm_ctc];

    // free-running prescaler, frozen while stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            psc <= '0;
        end else if (cs != cs_stop) begin
            psc <= psc + 6'd1;
        end
    end

    always_comb begin
        case (cs)
            cs_div1:  tick = 1'b1;
            cs_div8:  tick = (psc[2:0] == 3'b111);
            cs_div64: tick = (psc == 6'h3F);
            default:  tick = 1'b0;   // stopped
        endcase
    end

    // events only count on a tick
    assign match_a = tick && (tcnt0 == timer_cfg.ocr0a);
    assign match_b = tick && (tcnt0 == timer_cfg.ocr0b);
    assign ovf     = tick && (tcnt0 == 8'hFF);

    always_comb begin
        tcnt_next = tcnt0;
        if (tick) begin
            if (ctc_mode && match_a) begin
                tcnt_next = '0;   // top reached in ctc
            end else begin
                tcnt_next = tcnt0 + 8'd1;
            end
        end
    end

    // lands in tifr on the next edge
    always_comb begin
        flag_set            = '0;
        flag_set[bit_tov0]  = ovf;
        flag_set[bit_ocf0a] = match_a;
        flag_set[bit_ocf0b] = match_b;
    end

    // toggle at the same edge the flag is stored
    always_ff @(posedge clk) begin
        if (reset) begin
            oc0a <= 1'b0;
            oc0b <= 1'b0;
        end else begin
            if (match_a && timer_cfg.tccr0a[bit_com0a]) begin
                oc0a <= !oc0a;
            end
            if (match_b && timer_cfg.tccr0a[bit_com0b]) begin
                oc0b <= !oc0b;
            end
        end
    end

    // prescaler gaps never raise a flag
    no_flag_without_tick: assert property (
        @(posedge clk) disable iff (reset) !tick |-> (flag_set == '0)
    );

endmodule

// File: verilog.f
io_pkg.sv
io_regfile.sv
gpio_unit.sv
timer_unit.sv
interrupt_controller.sv
io_subsystem.sv
tb_io_subsystem.sv
